//--- Makefile
SRCS := $(wildcard rtl/*.sv verif/*.sv)

.PHONY: run clean

obj_dir/Vtb_uart_cmd: files.f $(SRCS)
	verilator --binary --timing -f files.f --top-module tb_uart_cmd -o Vtb_uart_cmd

run: obj_dir/Vtb_uart_cmd
	./obj_dir/Vtb_uart_cmd | tee sim.log
	grep -qx "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- files.f
rtl/uart_pkg.sv
rtl/uart_byte_if.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/uart_cmd_ctrl.sv
rtl/uart_cmd_top.sv
verif/uart_dev_model.sv
verif/tb_uart_cmd.sv

//--- rtl/uart_byte_if.sv
`default_nettype none

interface uart_byte_if (
  input wire clk
);

  logic                        start; // one cycle, only while busy is low
  logic [uart_pkg::DATA_W-1:0] data;
  logic                        busy;
  logic                        done;

  modport ctrl (
    input  clk,
    output start,
    output data,
    input  busy,
    input  done
  );

  modport tx (
    input  clk,
    input  start,
    input  data,
    output busy,
    output done
  );

endinterface

`default_nettype wire

//--- rtl/uart_cmd_ctrl.sv
`default_nettype none

module uart_cmd_ctrl (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire  [uart_pkg::CMD_W-1:0]  cmd_in,
  input  wire                         cmd_vld,
  output logic                        cmd_rdy,
  uart_byte_if.ctrl                   byte_if,
  output logic                        listen,
  input  wire  [uart_pkg::DATA_W-1:0] rx_data,
  input  wire                         rx_valid,
  input  wire                         rx_perr,
  output logic [uart_pkg::DATA_W-1:0] read_data,
  output logic                        read_rdy,
  output logic                        parity_err
);

  uart_pkg::cmd_state_t       state;
  logic [uart_pkg::CMD_W-1:0] cmd_q;
  logic [uart_pkg::GAP_W-1:0] gap_cnt;
  logic                       accept;
  logic                       is_wr;

  assign cmd_rdy = (state == uart_pkg::IDLE);
  assign accept  = cmd_vld && cmd_rdy;
  assign listen  = (state == uart_pkg::WAIT_RESP);
  assign is_wr   = cmd_q[uart_pkg::WR_BIT];

  // high byte first, held steady for the whole frame
  assign byte_if.data = (state == uart_pkg::SEND_LO) ? cmd_q[uart_pkg::DATA_W-1:0]
                                                     : cmd_q[uart_pkg::CMD_W-1:uart_pkg::DATA_W];

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= uart_pkg::IDLE;
      gap_cnt       <= '0;
      byte_if.start <= 1'b0;
      read_data     <= '0;
      read_rdy      <= 1'b0;
      parity_err    <= 1'b0;
    end
    else
    begin
      byte_if.start <= 1'b0;
      read_rdy      <= 1'b0;
      parity_err    <= 1'b0;
      case (state)
        uart_pkg::IDLE:
        begin
          if (accept)
          begin
            state         <= uart_pkg::SEND_HI;
            byte_if.start <= 1'b1;
          end
        end
        uart_pkg::SEND_HI:
        begin
          if (byte_if.done)
          begin
            state   <= uart_pkg::GAP;
            gap_cnt <= '0;
          end
        end
        uart_pkg::GAP:
        begin
          if (gap_cnt == uart_pkg::GAP_LAST)
          begin
            state         <= uart_pkg::SEND_LO;
            byte_if.start <= 1'b1;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        uart_pkg::SEND_LO:
        begin
          if (byte_if.done)
            state <= is_wr ? uart_pkg::IDLE : uart_pkg::WAIT_RESP;
        end
        uart_pkg::WAIT_RESP:
        begin
          // no timeout, a lost response parks here
          if (rx_valid)
          begin
            read_data <= rx_data;
            read_rdy  <= 1'b1;
            state     <= uart_pkg::REPORT;
          end
          else if (rx_perr)
          begin
            parity_err <= 1'b1;
            state      <= uart_pkg::REPORT;
          end
        end
        uart_pkg::REPORT: state <= uart_pkg::IDLE;
        default:          state <= uart_pkg::IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/uart_cmd_top.sv
`default_nettype none

module uart_cmd_top (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire  [uart_pkg::CMD_W-1:0]  cmd_in,
  input  wire                         cmd_vld,
  output logic                        cmd_rdy,
  input  wire                         rx,
  output logic                        tx,
  output logic [uart_pkg::DATA_W-1:0] read_data,
  output logic                        read_rdy,
  output logic                        parity_err
);

  logic                        listen;
  logic [uart_pkg::DATA_W-1:0] rx_data;
  logic                        rx_valid;
  logic                        rx_perr;

  uart_byte_if u_byte_if (.clk(clk));

  uart_cmd_ctrl u_cmd_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .byte_if    (u_byte_if.ctrl),
    .listen     (listen),
    .rx_data    (rx_data),
    .rx_valid   (rx_valid),
    .rx_perr    (rx_perr),
    .read_data  (read_data),
    .read_rdy   (read_rdy),
    .parity_err (parity_err)
  );

  uart_tx_frame u_tx_frame (
    .clk     (clk),
    .rst_n   (rst_n),
    .byte_if (u_byte_if.tx),
    .tx      (tx)
  );

  uart_rx_frame u_rx_frame (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .listen   (listen),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_perr  (rx_perr)
  );

endmodule

`default_nettype wire

//--- rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

  localparam int CMD_W      = 16;
  localparam int DATA_W     = 8;
  localparam int WR_BIT     = 15; // write flag in the high byte

  localparam int BAUD_DIV   = 16; // clocks per bit
  localparam int HALF_DIV   = BAUD_DIV / 2;
  localparam int GAP_CYCLES = 32;

  localparam int BAUD_W     = $clog2(BAUD_DIV);
  localparam int GAP_W      = $clog2(GAP_CYCLES);

  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(BAUD_DIV - 1);
  localparam logic [BAUD_W-1:0] BAUD_MID  = BAUD_W'(HALF_DIV);
  localparam logic [GAP_W-1:0]  GAP_LAST  = GAP_W'(GAP_CYCLES - 1);

  typedef enum logic [2:0] {
    IDLE,
    SEND_HI,
    SEND_LO,
    GAP,
    WAIT_RESP,
    REPORT
  } cmd_state_t;

endpackage

`default_nettype wire

//--- rtl/uart_rx_frame.sv
`default_nettype none

module uart_rx_frame (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         rx,
  input  wire                         listen,
  output logic [uart_pkg::DATA_W-1:0] rx_data,
  output logic                        rx_valid,
  output logic                        rx_perr
);

  logic                        rx_meta;
  logic                        rx_sync;
  logic                        rx_prev;
  logic                        fall;
  logic                        active;
  logic                        mid;
  logic [uart_pkg::BAUD_W-1:0] baud_cnt;
  logic [3:0]                  bit_cnt;
  logic [8:0]                  bits_q; // parity, data lsb first

  assign fall = rx_prev & ~rx_sync;
  assign mid  = active && (baud_cnt == uart_pkg::BAUD_MID);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      rx_perr  <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      rx_perr  <= 1'b0;
      if (!active)
      begin
        if (listen && fall)
        begin
          active   <= 1'b1;
          baud_cnt <= '0;
          bit_cnt  <= '0;
        end
      end
      else
      begin
        if (baud_cnt == uart_pkg::BAUD_LAST)
        begin
          baud_cnt <= '0;
          bit_cnt  <= bit_cnt + 4'd1;
        end
        else
        begin
          baud_cnt <= baud_cnt + 1'b1;
        end
        if (mid && bit_cnt == 4'd10)
        begin
          active <= 1'b0; // stop sample, frame finished
          if (bits_q[8] == ~^bits_q[7:0])
            rx_valid <= 1'b1;
          else
            rx_perr <= 1'b1;
        end
      end
    end
  end

  // start sample shifts through and drops out the bottom
  always_ff @(posedge clk)
  begin
    if (mid && bit_cnt != 4'd10)
      bits_q <= {rx_sync, bits_q[8:1]};
    if (mid && bit_cnt == 4'd10)
      rx_data <= bits_q[7:0];
  end

endmodule

`default_nettype wire

//--- rtl/uart_tx_frame.sv
`default_nettype none

module uart_tx_frame (
  input  wire         clk,
  input  wire         rst_n,
  uart_byte_if.tx     byte_if,
  output logic        tx
);

  logic [10:0]                 frame_q;
  logic [uart_pkg::BAUD_W-1:0] baud_cnt;
  logic [3:0]                  bit_cnt;
  logic                        baud_tick;

  assign baud_tick = (baud_cnt == uart_pkg::BAUD_LAST);

  // all ones once the frame has shifted out, so the line idles high
  assign tx = frame_q[0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_q      <= '1;
      baud_cnt     <= '0;
      bit_cnt      <= '0;
      byte_if.busy <= 1'b0;
      byte_if.done <= 1'b0;
    end
    else
    begin
      byte_if.done <= 1'b0;
      if (byte_if.start && !byte_if.busy)
      begin
        // stop, odd parity, data lsb first, start
        frame_q      <= {1'b1, ~^byte_if.data, byte_if.data, 1'b0};
        baud_cnt     <= '0;
        bit_cnt      <= '0;
        byte_if.busy <= 1'b1;
      end
      else if (byte_if.busy)
      begin
        if (baud_tick)
        begin
          baud_cnt <= '0;
          frame_q  <= {1'b1, frame_q[10:1]};
          if (bit_cnt == 4'd10)
          begin
            byte_if.busy <= 1'b0; // end of stop bit
            byte_if.done <= 1'b1;
          end
          else
          begin
            bit_cnt <= bit_cnt + 4'd1;
          end
        end
        else
        begin
          baud_cnt <= baud_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_uart_cmd.sv
`default_nettype none

module tb_uart_cmd;

  localparam int CLK_PERIOD      = 8;
  localparam int MAX_ENTRIES     = 16;
  localparam int CYCLES_PER_TEST = 3 * 11 * uart_pkg::BAUD_DIV + uart_pkg::GAP_CYCLES + 100;

  logic                        clk            = 1'b0;
  logic                        rst_n          = 1'b1;
  logic [uart_pkg::CMD_W-1:0]  cmd_in         = '0;
  logic                        cmd_vld        = 1'b0;
  logic                        corrupt_parity = 1'b0;
  logic                        cmd_rdy;
  logic                        tx;
  logic                        rx;
  logic [uart_pkg::DATA_W-1:0] read_data;
  logic                        read_rdy;
  logic                        parity_err;
  int                          bad_frames;

  // stimulus table
  string                       t_name     [MAX_ENTRIES];
  logic [uart_pkg::CMD_W-1:0]  t_cmd      [MAX_ENTRIES];
  logic                        t_corrupt  [MAX_ENTRIES];
  logic                        t_exp_rd   [MAX_ENTRIES];
  logic [uart_pkg::DATA_W-1:0] t_exp_data [MAX_ENTRIES];
  logic                        t_exp_pe   [MAX_ENTRIES];
  logic                        t_chain    [MAX_ENTRIES]; // keep cmd_vld high into next entry

  int   n_entries   = 0;
  int   errors      = 0;
  int   seed        = 15;
  logic table_ready = 1'b0;

  uart_cmd_top u_uart_cmd_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .rx         (rx),
    .tx         (tx),
    .read_data  (read_data),
    .read_rdy   (read_rdy),
    .parity_err (parity_err)
  );

  uart_dev_model u_dev_model (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx             (tx),
    .corrupt_parity (corrupt_parity),
    .tx             (rx),
    .bad_frames     (bad_frames)
  );

  initial
  begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    begin
      if (expected !== actual)
      begin
        $display("error %s expected %0h actual %0h", name, expected, actual);
        errors = errors + 1;
      end
    end
  endtask

  task automatic add_entry(input string name, input logic [uart_pkg::CMD_W-1:0] cmd,
                           input logic corrupt, input logic exp_rd,
                           input logic [uart_pkg::DATA_W-1:0] exp_data,
                           input logic exp_pe, input logic chain);
    begin
      t_name[n_entries]     = name;
      t_cmd[n_entries]      = cmd;
      t_corrupt[n_entries]  = corrupt;
      t_exp_rd[n_entries]   = exp_rd;
      t_exp_data[n_entries] = exp_data;
      t_exp_pe[n_entries]   = exp_pe;
      t_chain[n_entries]    = chain;
      n_entries = n_entries + 1;
    end
  endtask

  task automatic build_table();
    logic [uart_pkg::DATA_W-1:0] d [5];
    logic [uart_pkg::DATA_W-1:0] fresh;
    begin
      for (int k = 0; k < 5; k++)
        d[k] = 8'($random(seed));
      fresh = {1'b0, 7'h2A} ^ 8'h5A; // reset image of 0x2a
      add_entry("wr_a03", {1'b1, 7'h03, d[0]}, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0);
      add_entry("wr_a11", {1'b1, 7'h11, d[1]}, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0);
      add_entry("wr_a40", {1'b1, 7'h40, d[2]}, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0);
      add_entry("wr_a7f", {1'b1, 7'h7F, d[3]}, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0);
      add_entry("rd_a03", {1'b0, 7'h03, 8'h00}, 1'b0, 1'b1, d[0], 1'b0, 1'b0);
      add_entry("rd_a11", {1'b0, 7'h11, 8'h00}, 1'b0, 1'b1, d[1], 1'b0, 1'b0);
      add_entry("rd_a40", {1'b0, 7'h40, 8'h00}, 1'b0, 1'b1, d[2], 1'b0, 1'b0);
      add_entry("rd_a7f", {1'b0, 7'h7F, 8'h00}, 1'b0, 1'b1, d[3], 1'b0, 1'b0);
      add_entry("rd_untouched_a2a", {1'b0, 7'h2A, 8'h00}, 1'b0, 1'b1, fresh, 1'b0, 1'b0);
      // bad parity, read_data must keep the previous byte
      add_entry("rd_corrupt_a11", {1'b0, 7'h11, 8'h00}, 1'b1, 1'b0, fresh, 1'b1, 1'b0);
      add_entry("rd_a11_again", {1'b0, 7'h11, 8'h00}, 1'b0, 1'b1, d[1], 1'b0, 1'b0);
      add_entry("b2b_wr_a09", {1'b1, 7'h09, d[4]}, 1'b0, 1'b0, 8'h00, 1'b0, 1'b1);
      add_entry("b2b_rd_a09", {1'b0, 7'h09, 8'h00}, 1'b0, 1'b1, d[4], 1'b0, 1'b1);
      add_entry("b2b_rd_a40", {1'b0, 7'h40, 8'h00}, 1'b0, 1'b1, d[2], 1'b0, 1'b0);
    end
  endtask

  // starts and ends on a rising edge
  task automatic run_entry(input int i);
    int rdy_seen;
    int perr_seen;
    begin
      rdy_seen  = 0;
      perr_seen = 0;
      corrupt_parity <= t_corrupt[i];
      if (!cmd_vld)
      begin
        cmd_vld <= 1'b1;
        cmd_in  <= t_cmd[i];
        @(posedge clk);
      end
      while (!cmd_rdy)
        @(posedge clk);
      // accepted on this edge
      if (t_chain[i])
        cmd_in <= t_cmd[i+1];
      else
        cmd_vld <= 1'b0;
      @(posedge clk);
      compare_value({t_name[i], " cmd_rdy_after_accept"}, 0, cmd_rdy);
      while (!cmd_rdy)
      begin
        if (read_rdy)
          rdy_seen = rdy_seen + 1;
        if (parity_err)
          perr_seen = perr_seen + 1;
        @(posedge clk);
      end
      compare_value({t_name[i], " read_rdy_pulses"}, int'(t_exp_rd[i]), rdy_seen);
      compare_value({t_name[i], " parity_err_pulses"}, int'(t_exp_pe[i]), perr_seen);
      if (t_exp_rd[i] || t_exp_pe[i])
        compare_value({t_name[i], " read_data"}, int'(t_exp_data[i]), read_data);
    end
  endtask

  initial
  begin
    build_table();
    table_ready = 1'b1;
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    compare_value("reset cmd_rdy", 1, cmd_rdy);
    compare_value("reset tx", 1, tx);
    compare_value("reset read_rdy", 0, read_rdy);
    compare_value("reset parity_err", 0, parity_err);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < n_entries; i++)
      run_entry(i);
    compare_value("device frame format", 0, bad_frames);
    $display("%0d errors over %0d commands", errors, n_entries);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    wait (table_ready);
    #(n_entries * CYCLES_PER_TEST * CLK_PERIOD);
    $display("timeout, the DUT did not finish the command table in time");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/uart_dev_model.sv
`default_nettype none

module uart_dev_model (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  rx,             // command frames from the master
  input  wire  corrupt_parity,
  output logic tx,             // response frames back to the master
  output int   bad_frames
);

  logic [uart_pkg::DATA_W-1:0] image [0:127];

  // returns at the stop sample, before the stop bit ends
  task automatic recv_frame(output logic [uart_pkg::DATA_W-1:0] data);
    logic [8:0] bits;
    begin
      bits = '0;
      @(posedge clk);
      while (rx !== 1'b0)
        @(posedge clk);
      repeat (uart_pkg::HALF_DIV) @(posedge clk);
      if (rx !== 1'b0)
        bad_frames = bad_frames + 1; // start bit gone at mid point
      for (int i = 0; i < 9; i++)
      begin
        repeat (uart_pkg::BAUD_DIV) @(posedge clk);
        bits = {rx, bits[8:1]};
      end
      repeat (uart_pkg::BAUD_DIV) @(posedge clk);
      if (rx !== 1'b1 || bits[8] !== ~^bits[7:0])
        bad_frames = bad_frames + 1;
      data = bits[7:0];
    end
  endtask

  task automatic send_frame(input logic [uart_pkg::DATA_W-1:0] data, input logic bad_par);
    logic [10:0] frame;
    begin
      frame = {1'b1, (~^data) ^ bad_par, data, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
        tx <= frame[i];
        repeat (uart_pkg::BAUD_DIV) @(posedge clk);
      end
      tx <= 1'b1;
      // line stays high, so half a stop bit is enough before listening again
      repeat (uart_pkg::HALF_DIV) @(posedge clk);
    end
  endtask

  initial
  begin
    logic [uart_pkg::DATA_W-1:0] hi;
    logic [uart_pkg::DATA_W-1:0] lo;
    tx <= 1'b1;
    bad_frames = 0;
    for (int a = 0; a < 128; a++)
      image[a] = 8'(a) ^ 8'h5A;
    wait (rst_n === 1'b0);
    wait (rst_n === 1'b1);
    forever
    begin
      recv_frame(hi);
      recv_frame(lo);
      if (hi[uart_pkg::WR_BIT - uart_pkg::DATA_W])
        image[hi[6:0]] = lo;
      else
      begin
        repeat (2 * uart_pkg::BAUD_DIV) @(posedge clk); // turnaround
        send_frame(image[hi[6:0]], corrupt_parity);
      end
    end
  end

endmodule

`default_nettype wire
